// File: Bender.yml
package:
  name: data_path

sources:
  - rtl/mips_pkg.sv
  - rtl/pipe_reg.sv
  - rtl/instruction_fetch.sv
  - rtl/instruction_decode.sv
  - rtl/execute_unit.sv
  - rtl/register_bank.sv
  - rtl/data_path.sv
  - target: simulation
    files:
      - verification/data_path_checker.sv
      - verification/tb_data_path.sv

// File: list.f
rtl/mips_pkg.sv
rtl/pipe_reg.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execute_unit.sv
rtl/register_bank.sv
rtl/data_path.sv
verification/data_path_checker.sv
verification/tb_data_path.sv

// File: rtl/data_path.sv
module data_path
    import mips_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_pc_enable,
    input  logic                    i_im_write_enable,   // Debug load strobe
    input  im_addr_t                i_im_address,
    input  logic [NB_MEM_WIDTH-1:0] i_im_data,
    input  reg_addr_t               i_rb_address,        // Debug register select
    output logic                    o_hlt,
    output word_t                   o_pc_value,
    output word_t                   o_rb_data
);

    if_id_t    if_id_d;
    if_id_t    if_id_q;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_wb_t    ex_wb_d;
    ex_wb_t    ex_wb_q;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    instruction_fetch instruction_fetch_1 (
        .i_clock           (i_clock),
        .i_rst             (i_rst),
        .i_pc_enable       (i_pc_enable),
        .i_im_write_enable (i_im_write_enable),
        .i_im_address      (i_im_address),
        .i_im_data         (i_im_data),
        .o_if_id           (if_id_d),
        .o_pc_value        (o_pc_value)
    );

    pipe_reg #(.payload_t(if_id_t)) if_id_reg_1 (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_d     (if_id_d),
        .o_q     (if_id_q)
    );

    instruction_decode instruction_decode_1 (
        .i_if_id   (if_id_q),
        .o_rs_addr (rs_addr),
        .o_rt_addr (rt_addr),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_id_ex   (id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_1 (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_d     (id_ex_d),
        .o_q     (id_ex_q)
    );

    execute_unit execute_unit_1 (
        .i_id_ex (id_ex_q),
        .i_ex_wb (ex_wb_q),   // Forwarding source
        .o_ex_wb (ex_wb_d)
    );

    pipe_reg #(.payload_t(ex_wb_t)) ex_wb_reg_1 (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_d     (ex_wb_d),
        .o_q     (ex_wb_q)
    );

    register_bank register_bank_1 (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_ex_wb      (ex_wb_q),
        .i_rs_addr    (rs_addr),
        .i_rt_addr    (rt_addr),
        .i_rb_address (i_rb_address),
        .o_rs_data    (rs_data),
        .o_rt_data    (rt_data),
        .o_rb_data    (o_rb_data),
        .o_hlt        (o_hlt)
    );

endmodule

// File: rtl/execute_unit.sv
module execute_unit
    import mips_pkg::*;
(
    input  id_ex_t i_id_ex,
    input  ex_wb_t i_ex_wb,
    output ex_wb_t o_ex_wb
);

    logic  fwd_ok;
    logic  fwd_a;
    logic  fwd_b;
    word_t op_a;
    word_t op_b;
    word_t result;

    assign fwd_ok = i_ex_wb.valid && i_ex_wb.reg_write;
    assign fwd_a  = fwd_ok && (i_ex_wb.dest == i_id_ex.rs);
    assign fwd_b  = fwd_ok && i_id_ex.b_from_reg && (i_ex_wb.dest == i_id_ex.rt);

    assign op_a = fwd_a ? i_ex_wb.result : i_id_ex.operand_a;
    assign op_b = fwd_b ? i_ex_wb.result : i_id_ex.operand_b;   // Immediate never forwarded

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = word_t'($signed(op_a) < $signed(op_b));
            ALU_LUI: result = op_b << 16;
            default: result = '0;
        endcase
    end

    assign o_ex_wb.valid     = i_id_ex.valid;
    assign o_ex_wb.halt      = i_id_ex.halt;
    assign o_ex_wb.reg_write = i_id_ex.reg_write;
    assign o_ex_wb.dest      = i_id_ex.dest;
    assign o_ex_wb.result    = result;

    // Decode must hand over a defined operation for every live instruction
    a_alu_op_known: assert final (
        (i_id_ex.valid !== 1'b1) || !$isunknown(i_id_ex.alu_op)
    ) else $error("execute_unit: unknown alu_op on a valid instruction");

endmodule

// File: rtl/instruction_decode.sv
module instruction_decode
    import mips_pkg::*;
(
    input  if_id_t    i_if_id,
    output reg_addr_t o_rs_addr,
    output reg_addr_t o_rt_addr,
    input  word_t     i_rs_data,
    input  word_t     i_rt_data,
    output id_ex_t    o_id_ex
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;
    word_t       imm_ext;
    logic        known;
    logic        is_rtype;
    alu_op_e     alu_op;
    reg_addr_t   dest;

    assign opcode = i_if_id.instr[31:26];
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign funct  = i_if_id.instr[5:0];
    assign imm    = i_if_id.instr[15:0];

    always_comb begin
        known    = 1'b1;
        is_rtype = 1'b0;
        alu_op   = ALU_ADD;
        imm_ext  = {{16{imm[15]}}, imm};   // Sign extended by default
        case (opcode)
            OP_RTYPE: begin
                is_rtype = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_ANDI: begin
                alu_op  = ALU_AND;
                imm_ext = {16'b0, imm};
            end
            OP_ORI: begin
                alu_op  = ALU_OR;
                imm_ext = {16'b0, imm};
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;   // Shifted up in execute
                imm_ext = {16'b0, imm};
            end
            default: known = 1'b0;   // Halt lands here too
        endcase
    end

    assign dest = is_rtype ? rd : rt;

    assign o_rs_addr = rs;
    assign o_rt_addr = rt;

    assign o_id_ex.valid      = i_if_id.valid;
    assign o_id_ex.halt       = i_if_id.halt;
    assign o_id_ex.reg_write  = i_if_id.valid && known && !i_if_id.halt && (dest != '0);
    assign o_id_ex.alu_op     = alu_op;
    assign o_id_ex.operand_a  = i_rs_data;
    assign o_id_ex.operand_b  = is_rtype ? i_rt_data : imm_ext;
    assign o_id_ex.rs         = rs;
    assign o_id_ex.rt         = rt;
    assign o_id_ex.b_from_reg = is_rtype;
    assign o_id_ex.dest       = dest;

endmodule

// File: rtl/instruction_fetch.sv
module instruction_fetch
    import mips_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_pc_enable,
    input  logic                    i_im_write_enable,
    input  im_addr_t                i_im_address,
    input  logic [NB_MEM_WIDTH-1:0] i_im_data,
    output if_id_t                  o_if_id,
    output word_t                   o_pc_value
);

    logic [NB_MEM_WIDTH-1:0] imem [IM_DEPTH];
    word_t                   pc;
    logic                    stopped;
    im_addr_t                byte_addr;
    word_t                   instr;
    logic                    fetch_en;
    logic                    is_halt;

    always_ff @(posedge i_clock) begin
        if (i_im_write_enable) begin
            imem[i_im_address] <= i_im_data;   // Debug load
        end
    end

    assign byte_addr = pc[NB_IM_ADDR-1:0];

    always_comb begin
        for (int i = 0; i < NB_DATA / NB_MEM_WIDTH; i++) begin
            instr[NB_DATA-1-NB_MEM_WIDTH*i -: NB_MEM_WIDTH] = imem[byte_addr + im_addr_t'(i)];
        end
    end

    assign fetch_en = i_pc_enable && !stopped;
    assign is_halt  = (instr[31:26] == OP_HALT);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc      <= '0;
            stopped <= 1'b0;
        end else if (fetch_en) begin
            pc <= pc + word_t'(4);
            if (is_halt) begin
                stopped <= 1'b1;   // PC parks past the halt word
            end
        end
    end

    assign o_if_id.valid = fetch_en;
    assign o_if_id.halt  = fetch_en && is_halt;
    assign o_if_id.instr = instr;
    assign o_if_id.pc    = pc;

    assign o_pc_value = pc;

    // Loading is only allowed while the core is paused
    a_no_load_while_running: assert property (
        @(posedge i_clock) disable iff (i_rst)
        i_im_write_enable |-> !i_pc_enable
    ) else $error("instruction_fetch: memory write while running");

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

    localparam int NB_DATA      = 32;
    localparam int NB_REG       = 5;
    localparam int NB_IM_ADDR   = 8;
    localparam int NB_MEM_WIDTH = 8;
    localparam int IM_DEPTH     = 256;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_HALT  = 6'h3f;   // All ones

    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef logic [NB_DATA-1:0]    word_t;
    typedef logic [NB_REG-1:0]     reg_addr_t;
    typedef logic [NB_IM_ADDR-1:0] im_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        logic  halt;
        word_t instr;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        logic      halt;
        logic      reg_write;
        alu_op_e   alu_op;
        word_t     operand_a;
        word_t     operand_b;
        reg_addr_t rs;
        reg_addr_t rt;
        logic      b_from_reg;   // Operand b came from rt
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      halt;
        logic      reg_write;
        reg_addr_t dest;
        word_t     result;
    } ex_wb_t;

endpackage

// File: rtl/pipe_reg.sv
module pipe_reg
    import mips_pkg::*;
#(
    parameter type payload_t = if_id_t
) (
    input  logic     i_clock,
    input  logic     i_rst,
    input  payload_t i_d,
    output payload_t o_q
);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_q <= '0;   // Bubble
        end else begin
            o_q <= i_d;
        end
    end

    // A stage that ever carries an unknown valid would poison every later stage
    a_valid_known: assert property (
        @(posedge i_clock) disable iff (i_rst)
        !$isunknown(o_q.valid)
    ) else $error("pipe_reg: valid bit unknown");

endmodule

// File: rtl/register_bank.sv
module register_bank
    import mips_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_rst,
    input  ex_wb_t    i_ex_wb,
    input  reg_addr_t i_rs_addr,
    input  reg_addr_t i_rt_addr,
    input  reg_addr_t i_rb_address,
    output word_t     o_rs_data,
    output word_t     o_rt_data,
    output word_t     o_rb_data,
    output logic      o_hlt
);

    word_t regs [2**NB_REG];
    logic  wr_en;

    assign wr_en = i_ex_wb.valid && i_ex_wb.reg_write;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 2**NB_REG; i++) begin
                regs[i] <= '0;
            end
            o_hlt <= 1'b0;
        end else begin
            if (wr_en) begin
                regs[i_ex_wb.dest] <= i_ex_wb.result;
            end
            if (i_ex_wb.valid && i_ex_wb.halt) begin
                o_hlt <= 1'b1;   // Sticky until reset
            end
        end
    end

    // Write-first on decode ports
    always_comb begin
        o_rs_data = (wr_en && i_ex_wb.dest == i_rs_addr) ? i_ex_wb.result : regs[i_rs_addr];
        o_rt_data = (wr_en && i_ex_wb.dest == i_rt_addr) ? i_ex_wb.result : regs[i_rt_addr];
        o_rb_data = regs[i_rb_address];
        if (i_rs_addr == '0) begin
            o_rs_data = '0;
        end
        if (i_rt_addr == '0) begin
            o_rt_data = '0;
        end
        if (i_rb_address == '0) begin
            o_rb_data = '0;
        end
    end

    a_no_r0_write: assert property (
        @(posedge i_clock) disable iff (i_rst)
        wr_en |-> (i_ex_wb.dest != '0)
    ) else $error("register_bank: write to register 0");

endmodule

// File: verification/data_path_checker.sv
module data_path_checker
    import mips_pkg::*;
(
    input  logic            i_clock,
    input  logic [8*16-1:0] i_test_name,
    input  word_t           i_expected,
    input  logic            i_check_reg,
    input  logic            i_check_pc,
    input  logic            i_check_halt_low,
    input  logic            i_test_end,
    input  logic            i_timeout,
    input  logic            i_report,
    input  reg_addr_t       i_rb_address,
    input  word_t           i_rb_data,
    input  word_t           i_pc_value,
    input  logic            i_hlt,
    output logic            o_failed
);

    timeunit 1ns;
    timeprecision 1ps;

    int tests       = 0;
    int checks      = 0;
    int errors      = 0;
    int test_checks = 0;
    int test_errors = 0;

    task automatic compare(input string what, input word_t actual);
        checks++;
        test_checks++;
        if (actual !== i_expected) begin
            errors++;
            test_errors++;
            $display("Error: test %0s, %0s expected %h actual %h",
                     i_test_name, what, i_expected, actual);
        end
    endtask

    // Strobes come 10 ns after an edge, so the next edge sees settled outputs
    always @(posedge i_clock) begin
        if (i_check_reg) begin
            compare($sformatf("r%0d", i_rb_address), i_rb_data);
        end
        if (i_check_pc) begin
            compare("pc", i_pc_value);
        end
        if (i_check_halt_low) begin
            compare("hlt", word_t'(i_hlt));
        end
        if (i_timeout) begin
            errors++;
            test_errors++;
            $display("Test %0s: halt never asserted within the cycle limit", i_test_name);
        end
        if (i_test_end) begin
            tests++;
            if (test_errors == 0) begin
                $display("Test %0s passed, %0d checks", i_test_name, test_checks);
            end else begin
                $display("Test %0s failed, %0d errors in %0d checks",
                         i_test_name, test_errors, test_checks);
            end
            test_checks = 0;
            test_errors = 0;
        end
        if (i_report) begin
            $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        end
    end

    assign o_failed = (errors != 0);

endmodule

// File: verification/data_path_trace.txt
# test <name> | reset | run | prog <byte addr> <four words, stored big-endian>
# reg <index> <expected> | pc <expected> | halt_low     (all numbers hex)
test rtype_imm
prog 00 24010007 2402fffd 00221821 00222023
prog 10 00222824 00223025 00223826 0041402a
prog 20 0022482a fc000000 240a0001 24010055
run
pc 00000028
reg 01 00000007
reg 02 fffffffd
reg 03 00000004
reg 04 0000000a
reg 05 00000005
reg 06 ffffffff
reg 07 fffffffa
reg 08 00000001
reg 09 00000000
reg 0a 00000000
test imm_hazard
reset
prog 00 3c011234 3421abcd 3022ff0f 34038001
prog 10 00222021 24000005 fc000000 340500ff
run
pc 0000001c
reg 01 1234abcd
reg 02 0000ab0d
reg 03 00008001
reg 04 123556da
reg 00 00000000
reg 05 00000000
test reset
reset
halt_low
pc 00000000
reg 01 00000000
reg 04 00000000
reg 07 00000000

// File: verification/tb_data_path.sv
module tb_data_path
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    HALT_TIMEOUT = 200;   // Cycles
    localparam int    DRIVE_DELAY  = 10;
    localparam string TRACE_FILE   = "verification/data_path_trace.txt";

    logic                    i_clock;
    logic                    i_rst;
    logic                    i_pc_enable;
    logic                    i_im_write_enable;
    im_addr_t                i_im_address;
    logic [NB_MEM_WIDTH-1:0] i_im_data;
    reg_addr_t               i_rb_address;
    logic                    o_hlt;
    word_t                   o_pc_value;
    word_t                   o_rb_data;

    logic            check_reg;
    logic            check_pc;
    logic            check_halt_low;
    logic            test_end;
    logic            halt_timeout;
    logic            report;
    word_t           expected;
    logic [8*16-1:0] test_name;
    logic            failed;
    logic            in_test;
    logic            trace_ok;

    data_path i_data_path (
        .i_clock           (i_clock),
        .i_rst             (i_rst),
        .i_pc_enable       (i_pc_enable),
        .i_im_write_enable (i_im_write_enable),
        .i_im_address      (i_im_address),
        .i_im_data         (i_im_data),
        .i_rb_address      (i_rb_address),
        .o_hlt             (o_hlt),
        .o_pc_value        (o_pc_value),
        .o_rb_data         (o_rb_data)
    );

    data_path_checker checker_1 (
        .i_clock          (i_clock),
        .i_test_name      (test_name),
        .i_expected       (expected),
        .i_check_reg      (check_reg),
        .i_check_pc       (check_pc),
        .i_check_halt_low (check_halt_low),
        .i_test_end       (test_end),
        .i_timeout        (halt_timeout),
        .i_report         (report),
        .i_rb_address     (i_rb_address),
        .i_rb_data        (o_rb_data),
        .i_pc_value       (o_pc_value),
        .i_hlt            (o_hlt),
        .o_failed         (failed)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    task automatic next_cycle();
        @(posedge i_clock);
        #DRIVE_DELAY;
    endtask

    task automatic reset_dut();
        i_rst = 1'b1;
        repeat (5) next_cycle();
        i_rst = 1'b0;
    endtask

    task automatic load_word(input word_t addr, input word_t word);
        for (int b = 0; b < 4; b++) begin
            i_im_write_enable = 1'b1;
            i_im_address      = im_addr_t'(addr + word_t'(b));
            i_im_data         = word[31-8*b -: 8];   // Big-endian
            next_cycle();
        end
        i_im_write_enable = 1'b0;
    endtask

    task automatic run_program();
        int cycles;
        cycles      = 0;
        i_pc_enable = 1'b1;
        while (o_hlt !== 1'b1 && cycles < HALT_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        i_pc_enable = 1'b0;
        if (o_hlt !== 1'b1) begin
            halt_timeout = 1'b1;
            next_cycle();
            halt_timeout = 1'b0;
        end
    endtask

    task automatic check_register(input reg_addr_t idx, input word_t value);
        i_rb_address = idx;
        expected     = value;
        check_reg    = 1'b1;
        next_cycle();
        check_reg    = 1'b0;
    endtask

    task automatic expect_pc(input word_t value);
        expected = value;
        check_pc = 1'b1;
        next_cycle();
        check_pc = 1'b0;
    endtask

    task automatic confirm_halt_low();
        expected       = '0;
        check_halt_low = 1'b1;
        next_cycle();
        check_halt_low = 1'b0;
    endtask

    task automatic close_test();
        if (in_test) begin
            test_end = 1'b1;
            next_cycle();
            test_end = 1'b0;
            in_test  = 1'b0;
        end
    endtask

    task automatic request_counts();
        report = 1'b1;
        next_cycle();
        report = 1'b0;
    endtask

    task automatic require_fields(input int got, input int want);
        if (got != want) begin
            $display("Trace file line is missing fields or has a bad number");
            trace_ok = 1'b0;
        end
    endtask

    initial begin
        int               fd;
        int               n;
        logic [8*8-1:0]   kind;
        logic [8*128-1:0] rest;
        word_t            base;
        word_t            word;
        word_t            value;

        i_rst             = 1'b1;
        i_pc_enable       = 1'b0;
        i_im_write_enable = 1'b0;
        i_im_address      = '0;
        i_im_data         = '0;
        i_rb_address      = '0;
        check_reg         = 1'b0;
        check_pc          = 1'b0;
        check_halt_low    = 1'b0;
        test_end          = 1'b0;
        halt_timeout      = 1'b0;
        report            = 1'b0;
        expected          = '0;
        test_name         = '0;
        in_test           = 1'b0;
        trace_ok          = 1'b1;

        reset_dut();
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open trace file %0s", TRACE_FILE);
            trace_ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                case (kind)
                    "#": n = $fgets(rest, fd);   // Rest of a comment line
                    "test": begin
                        close_test();
                        n       = $fscanf(fd, "%s", test_name);
                        require_fields(n, 1);
                        in_test = 1'b1;
                    end
                    "prog": begin
                        n = $fscanf(fd, "%h", base);
                        require_fields(n, 1);
                        for (int w = 0; w < 4; w++) begin
                            n = $fscanf(fd, "%h", word);
                            require_fields(n, 1);
                            load_word(base + word_t'(4 * w), word);
                        end
                    end
                    "run": run_program();
                    "reset": reset_dut();
                    "reg": begin
                        n = $fscanf(fd, "%h %h", base, value);
                        require_fields(n, 2);
                        check_register(reg_addr_t'(base), value);
                    end
                    "pc": begin
                        n = $fscanf(fd, "%h", value);
                        require_fields(n, 1);
                        expect_pc(value);
                    end
                    "halt_low": confirm_halt_low();
                    default: begin
                        $display("Unknown trace entry %0s", kind);
                        trace_ok = 1'b0;
                    end
                endcase
            end
            $fclose(fd);
        end
        close_test();
        request_counts();
        if (failed || !trace_ok) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule
